// ==== common/gpio_config.svh ====
// GPIO register map and sizes

`ifndef GPIO_CONFIG_SVH
`define GPIO_CONFIG_SVH

//////////////////////////////////////////////////
// Address decode
//////////////////////////////////////////////////

`define GPIO_DEC_WD     6         // Bits used by the local decoder
`define GPIO_BASE_ADDR  15'h0000  // Byte address, aligned to decoder width

// First word address of each port window
`define GPIO_P1_WORD    5'h10
`define GPIO_P2_WORD    5'h14

//////////////////////////////////////////////////
// Per-port register offsets
//////////////////////////////////////////////////

`define GPIO_NUM_REGS   7

// Even offsets use the low lane, odd ones the high lane
`define GPIO_REG_IN     0
`define GPIO_REG_OUT    1
`define GPIO_REG_DIR    2
`define GPIO_REG_IFG    3
`define GPIO_REG_IES    4
`define GPIO_REG_IE     5
`define GPIO_REG_SEL    6

`define GPIO_SYNC_STAGES 2  // Input synchronizer depth

`endif

// ==== common/gpio_pkg.sv ====
// GPIO shared types

package gpio_pkg;

  //////////////////////////////////////////////////
  // Peripheral bus word
  //////////////////////////////////////////////////

  // Byte lanes of the 16-bit peripheral bus
  typedef struct packed {
    logic [7:0] hi;  // Odd register offset
    logic [7:0] lo;  // Even register offset
  } per_bytes_t;

  // One bus word, seen either whole or as two lanes.
  // Registers are byte wide, so lane placement matters on every access
  typedef union packed {
    logic [15:0] word;
    per_bytes_t  bytes;
  } per_word_t;

endpackage

// ==== common/gpio_reg_if.sv ====
// GPIO decoder to port register bus

`timescale 1ns/1ps

`include "gpio_config.svh"

interface gpio_reg_if
  import gpio_pkg::*;
();

  logic [`GPIO_NUM_REGS-1:0] wr;       // One-hot write strobe per offset
  logic [`GPIO_NUM_REGS-1:0] rd;       // One-hot read select per offset
  logic [7:0]                wr_data;  // Byte from the selected lane
  per_word_t                 rd_word;  // Zero when nothing is read

  modport decoder (
    output wr,
    output rd,
    output wr_data,
    input  rd_word
  );

  modport port (
    input  wr,
    input  rd,
    input  wr_data,
    output rd_word
  );

endinterface

// ==== gpio_port/gpio_input_sync.sv ====
// GPIO input synchronizer

`timescale 1ns/1ps

`include "gpio_config.svh"

module gpio_input_sync (
  input  logic       mclk,
  input  logic       puc_rst,
  input  logic [7:0] din,   // Asynchronous pins
  output logic [7:0] sync   // Safe to use in the mclk domain
);

  localparam int NSTG = `GPIO_SYNC_STAGES;

  // Stage 0 sees the pins first
  logic [NSTG-1:0][7:0] chain;

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      chain <= '0;
    end else begin
      chain <= {chain[NSTG-2:0], din};
    end
  end

  assign sync = chain[NSTG-1];  // Last stage

endmodule

// ==== gpio_port/gpio_port.sv ====
// GPIO port registers and interrupt

`timescale 1ns/1ps

`include "gpio_config.svh"

module gpio_port
  import gpio_pkg::*;
(
  input  logic       mclk,
  input  logic       puc_rst,
  input  logic [7:0] din,      // Pins in, asynchronous
  output logic [7:0] dout,     // OUT register
  output logic [7:0] dout_en,  // DIR register
  output logic [7:0] sel,      // SEL register
  output logic       irq,      // Port interrupt request
  gpio_reg_if.port   bus
);

  localparam int NREG = `GPIO_NUM_REGS;

  logic [7:0] in_sync;    // Synchronized pins, the IN register
  logic [7:0] in_dly;     // IN one cycle later
  logic [7:0] out_r;
  logic [7:0] dir_r;
  logic [7:0] ifg_r;
  logic [7:0] ies_r;      // 1 selects falling edge
  logic [7:0] ie_r;
  logic [7:0] sel_r;
  logic [7:0] in_re;
  logic [7:0] in_fe;
  logic [7:0] ifg_set;
  logic [7:0] reg_val [NREG];
  per_word_t  rd_acc;

  gpio_input_sync u_sync (
    .mclk    (mclk),
    .puc_rst (puc_rst),
    .din     (din),
    .sync    (in_sync)
  );

  //////////////////////////////////////////////////
  // Control registers
  //////////////////////////////////////////////////

  // IN has no storage here, its write strobe is ignored
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      out_r <= '0;
      dir_r <= '0;
      ies_r <= '0;
      ie_r  <= '0;
      sel_r <= '0;
    end else begin
      if (bus.wr[`GPIO_REG_OUT]) out_r <= bus.wr_data;
      if (bus.wr[`GPIO_REG_DIR]) dir_r <= bus.wr_data;
      if (bus.wr[`GPIO_REG_IES]) ies_r <= bus.wr_data;
      if (bus.wr[`GPIO_REG_IE])  ie_r  <= bus.wr_data;
      if (bus.wr[`GPIO_REG_SEL]) sel_r <= bus.wr_data;
    end
  end

  assign dout    = out_r;
  assign dout_en = dir_r;
  assign sel     = sel_r;

  //////////////////////////////////////////////////
  // Edge detect and flags
  //////////////////////////////////////////////////

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      in_dly <= '0;
    end else begin
      in_dly <= in_sync;
    end
  end

  assign in_re   = in_sync & ~in_dly;
  assign in_fe   = ~in_sync & in_dly;
  assign ifg_set = (ies_r & in_fe) | (~ies_r & in_re);

  // An edge in the write cycle still sets its flag
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      ifg_r <= '0;
    end else if (bus.wr[`GPIO_REG_IFG]) begin
      ifg_r <= bus.wr_data | ifg_set;
    end else begin
      ifg_r <= ifg_r | ifg_set;
    end
  end

  assign irq = |(ie_r & ifg_r);

  //////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////

  always_comb begin
    reg_val[`GPIO_REG_IN]  = in_sync;
    reg_val[`GPIO_REG_OUT] = out_r;
    reg_val[`GPIO_REG_DIR] = dir_r;
    reg_val[`GPIO_REG_IFG] = ifg_r;
    reg_val[`GPIO_REG_IES] = ies_r;
    reg_val[`GPIO_REG_IE]  = ie_r;
    reg_val[`GPIO_REG_SEL] = sel_r;
  end

  // Lane follows the offset's low bit
  always_comb begin
    rd_acc.word = '0;
    for (int i = 0; i < NREG; i++) begin
      if (bus.rd[i]) begin
        if (i[0]) begin
          rd_acc.bytes.hi = rd_acc.bytes.hi | reg_val[i];
        end else begin
          rd_acc.bytes.lo = rd_acc.bytes.lo | reg_val[i];
        end
      end
    end
  end

  assign bus.rd_word = rd_acc;

endmodule

// ==== verilog/gpio_reg_decoder.sv ====
// GPIO register decoder

`timescale 1ns/1ps

`include "gpio_config.svh"

module gpio_reg_decoder
  import gpio_pkg::*;
(
  input  logic [13:0]      per_addr,
  input  logic [15:0]      per_din,
  input  logic             per_en,
  input  logic [1:0]       per_we,
  output per_word_t        per_dout,
  gpio_reg_if.decoder      p1_bus,
  gpio_reg_if.decoder      p2_bus
);

  localparam int                NREG      = `GPIO_NUM_REGS;
  localparam logic [14:0]       BASE_ADDR = `GPIO_BASE_ADDR;
  localparam logic [4:0]        P1_WORD   = `GPIO_P1_WORD;
  localparam logic [4:0]        P2_WORD   = `GPIO_P2_WORD;
  localparam logic [NREG-1:0]   ONE_HOT   = 1;

  logic            reg_sel;     // Access falls inside the GPIO block
  logic            p1_hit;
  logic            p2_hit;
  logic [1:0]      word_idx;    // Word within a port window
  logic            lo_wr;
  logic            hi_wr;
  logic            rd_acc;
  logic [NREG-1:0] lo_sel;      // Even register of the word
  logic [NREG-1:0] hi_sel;      // Odd register, none for the last word
  logic [NREG-1:0] wr_vec;
  logic [NREG-1:0] rd_vec;
  per_word_t       din_w;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  assign reg_sel = per_en &
                   (per_addr[13:`GPIO_DEC_WD-1] == BASE_ADDR[14:`GPIO_DEC_WD]);

  // Four words per port window
  assign p1_hit = reg_sel & (per_addr[`GPIO_DEC_WD-2:2] == P1_WORD[`GPIO_DEC_WD-2:2]);
  assign p2_hit = reg_sel & (per_addr[`GPIO_DEC_WD-2:2] == P2_WORD[`GPIO_DEC_WD-2:2]);

  assign word_idx = per_addr[1:0];
  assign lo_sel   = ONE_HOT << {word_idx, 1'b0};
  assign hi_sel   = ONE_HOT << {word_idx, 1'b1};  // Shifts out past SEL

  //////////////////////////////////////////////////
  // Byte-lane strobes
  //////////////////////////////////////////////////

  // Registers are bytes with one shared data byte per port bus.
  // A two-lane write lands in the even register only
  assign lo_wr  = per_we[0];
  assign hi_wr  = per_we[1] & ~per_we[0];
  assign rd_acc = ~|per_we;

  assign wr_vec = (lo_sel & {NREG{lo_wr}}) | (hi_sel & {NREG{hi_wr}});
  assign rd_vec = (lo_sel | hi_sel) & {NREG{rd_acc}};

  assign din_w.word = per_din;

  assign p1_bus.wr      = wr_vec & {NREG{p1_hit}};
  assign p1_bus.rd      = rd_vec & {NREG{p1_hit}};
  assign p1_bus.wr_data = hi_wr ? din_w.bytes.hi : din_w.bytes.lo;

  assign p2_bus.wr      = wr_vec & {NREG{p2_hit}};
  assign p2_bus.rd      = rd_vec & {NREG{p2_hit}};
  assign p2_bus.wr_data = hi_wr ? din_w.bytes.hi : din_w.bytes.lo;

  //////////////////////////////////////////////////
  // Read data combine
  //////////////////////////////////////////////////

  // Unselected ports return zero, so a plain OR is enough
  assign per_dout.word = p1_bus.rd_word.word | p2_bus.rd_word.word;

endmodule

// ==== verilog/gpio_top.sv ====
// GPIO peripheral top level

`timescale 1ns/1ps

module gpio_top
  import gpio_pkg::*;
(
  input  logic        mclk,        // Main system clock
  input  logic        puc_rst,     // Main system reset
  input  logic [13:0] per_addr,    // Peripheral word address
  input  logic [15:0] per_din,     // Peripheral write data
  input  logic        per_en,      // Peripheral access enable
  input  logic [1:0]  per_we,      // Byte write enables
  input  logic [7:0]  p1_din,      // Port 1 pins in
  input  logic [7:0]  p2_din,      // Port 2 pins in
  output logic [15:0] per_dout,    // Peripheral read data
  output logic        irq_port1,
  output logic        irq_port2,
  output logic [7:0]  p1_dout,
  output logic [7:0]  p1_dout_en,
  output logic [7:0]  p1_sel,
  output logic [7:0]  p2_dout,
  output logic [7:0]  p2_dout_en,
  output logic [7:0]  p2_sel
);

  //////////////////////////////////////////////////
  // Register buses
  //////////////////////////////////////////////////

  gpio_reg_if p1_if ();
  gpio_reg_if p2_if ();

  per_word_t dec_dout;

  assign per_dout = dec_dout.word;

  //////////////////////////////////////////////////
  // Decoder and ports
  //////////////////////////////////////////////////

  gpio_reg_decoder u_dec (
    .per_addr (per_addr),
    .per_din  (per_din),
    .per_en   (per_en),
    .per_we   (per_we),
    .per_dout (dec_dout),
    .p1_bus   (p1_if),
    .p2_bus   (p2_if)
  );

  gpio_port u_port1 (
    .mclk    (mclk),
    .puc_rst (puc_rst),
    .din     (p1_din),
    .dout    (p1_dout),
    .dout_en (p1_dout_en),
    .sel     (p1_sel),
    .irq     (irq_port1),
    .bus     (p1_if)
  );

  gpio_port u_port2 (
    .mclk    (mclk),
    .puc_rst (puc_rst),
    .din     (p2_din),
    .dout    (p2_dout),
    .dout_en (p2_dout_en),
    .sel     (p2_sel),
    .irq     (irq_port2),
    .bus     (p2_if)
  );

endmodule

// ==== dv/gpio_props.sv ====
// GPIO bound checks

`timescale 1ns/1ps

`include "gpio_config.svh"

module gpio_props (
  input logic        mclk,
  input logic        puc_rst,
  input logic [13:0] per_addr,
  input logic [15:0] per_din,
  input logic        per_en,
  input logic [1:0]  per_we,
  input logic [7:0]  p1_din,
  input logic [7:0]  p2_din,
  input logic [15:0] per_dout,
  input logic        irq_port1,
  input logic        irq_port2,
  input logic [7:0]  p1_dout,
  input logic [7:0]  p1_dout_en,
  input logic [7:0]  p1_sel,
  input logic [7:0]  p2_dout,
  input logic [7:0]  p2_dout_en,
  input logic [7:0]  p2_sel
);

  localparam int          NP     = 2;
  localparam int          NREG   = `GPIO_NUM_REGS;
  localparam logic [13:0] P1_WIN = 14'((`GPIO_BASE_ADDR >> 1) + `GPIO_P1_WORD);
  localparam logic [13:0] P2_WIN = 14'((`GPIO_BASE_ADDR >> 1) + `GPIO_P2_WORD);

  int          val_errs = 0;
  int          rst_errs = 0;
  logic [7:0]  sh [NP][NREG];  // Shadow registers with the IN slot left at zero
  logic [7:0]  s1 [NP];        // Pin delay line whose s2 stage is the expected IN
  logic [7:0]  s2 [NP];
  logic [7:0]  s3 [NP];
  logic [7:0]  din_v [NP];
  logic [7:0]  set_v [NP];     // Expected flag sets this cycle
  logic        hit [NP];
  logic [2:0]  lo_off;
  logic [2:0]  hi_off;
  logic [15:0] exp_dout;
  logic [47:0] exp_io;
  logic [1:0]  exp_irq;
  logic [47:0] port_io;

  assign port_io = {p2_dout, p2_dout_en, p2_sel, p1_dout, p1_dout_en, p1_sel};

  //////////////////////////////////////////////////
  // Expected values
  //////////////////////////////////////////////////

  always_comb begin
    din_v[0] = p1_din;
    din_v[1] = p2_din;
    hit[0]   = per_en && (per_addr[13:2] == P1_WIN[13:2]);
    hit[1]   = per_en && (per_addr[13:2] == P2_WIN[13:2]);
    lo_off   = {per_addr[1:0], 1'b0};
    hi_off   = {per_addr[1:0], 1'b1};
    exp_dout = '0;
    for (int p = 0; p < NP; p++) begin
      // IES bit high picks the falling edge
      set_v[p] = (sh[p][`GPIO_REG_IES] & ~s2[p] & s3[p]) |
                 (~sh[p][`GPIO_REG_IES] & s2[p] & ~s3[p]);
      exp_irq[p] = |(sh[p][`GPIO_REG_IE] & sh[p][`GPIO_REG_IFG]);
      if (hit[p] && per_we == 2'b00) begin
        exp_dout[7:0] = (lo_off == `GPIO_REG_IN) ? s2[p] : sh[p][lo_off];
        if (hi_off < NREG) exp_dout[15:8] = sh[p][hi_off];
      end
    end
    exp_io = {sh[1][`GPIO_REG_OUT], sh[1][`GPIO_REG_DIR], sh[1][`GPIO_REG_SEL],
              sh[0][`GPIO_REG_OUT], sh[0][`GPIO_REG_DIR], sh[0][`GPIO_REG_SEL]};
  end

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      for (int p = 0; p < NP; p++) begin
        s1[p] <= '0;
        s2[p] <= '0;
        s3[p] <= '0;
        for (int r = 0; r < NREG; r++) sh[p][r] <= '0;
      end
    end else begin
      for (int p = 0; p < NP; p++) begin
        s1[p] <= din_v[p];
        s2[p] <= s1[p];
        s3[p] <= s2[p];
        sh[p][`GPIO_REG_IFG] <= sh[p][`GPIO_REG_IFG] | set_v[p];
        if (hit[p] && per_we[0] && lo_off != `GPIO_REG_IN) begin
          sh[p][lo_off] <= per_din[7:0];
        end
        if (hit[p] && per_we[1] && hi_off < NREG) begin
          sh[p][hi_off] <= per_din[15:8] | ((hi_off == `GPIO_REG_IFG) ? set_v[p] : 8'h00);
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  a_reset: assert property (@(posedge mclk)
    puc_rst |-> (per_dout == '0 && port_io == '0 && !irq_port1 && !irq_port2))
    else begin
      rst_errs++;
      $error("Outputs, irq lines or per_dout were not zero while reset was held");
    end

  a_io: assert property (@(posedge mclk) port_io == exp_io)
    else begin
      val_errs++;
      $error("Mismatch p2/p1 dout,dout_en,sel: got %h exp %h", $sampled(port_io),
             $sampled(exp_io));
    end

  a_dout: assert property (@(posedge mclk) per_dout == exp_dout)
    else begin
      val_errs++;
      $error("Mismatch per_dout: got %h exp %h", $sampled(per_dout), $sampled(exp_dout));
    end

  a_irq: assert property (@(posedge mclk) {irq_port2, irq_port1} == exp_irq)
    else begin
      val_errs++;
      $error("Mismatch irq_port2,irq_port1: got %h exp %h",
             $sampled({irq_port2, irq_port1}), $sampled(exp_irq));
    end

endmodule

bind gpio_top gpio_props u_props (.*);

// ==== dv/gpio_tb.sv ====
// GPIO testbench

`timescale 1ns/1ps

`include "gpio_config.svh"

module gpio_tb;

  localparam int MAX_CYCLES = 600;  // Sequence needs under 300

  logic        mclk;
  logic        puc_rst;
  logic [13:0] per_addr;
  logic [15:0] per_din;
  logic        per_en;
  logic [1:0]  per_we;
  logic [7:0]  p1_din;
  logic [7:0]  p2_din;
  logic [15:0] per_dout;
  logic        irq_port1;
  logic        irq_port2;
  logic [7:0]  p1_dout;
  logic [7:0]  p1_dout_en;
  logic [7:0]  p1_sel;
  logic [7:0]  p2_dout;
  logic [7:0]  p2_dout_en;
  logic [7:0]  p2_sel;
  int          cycles = 0;
  bit          timed_out = 1'b0;

  gpio_top uut (.*);

  always #20 mclk = ~mclk;

  //////////////////////////////////////////////////
  // Bus and pin helpers
  //////////////////////////////////////////////////

  function automatic logic [13:0] word_addr(int port, int idx);
    return 14'((`GPIO_BASE_ADDR >> 1) + (port == 0 ? `GPIO_P1_WORD : `GPIO_P2_WORD) + idx);
  endfunction

  // Drives one access cycle and returns the bus to idle
  task automatic bus_cycle(logic [13:0] addr, logic [15:0] data, logic en, logic [1:0] we);
    @(negedge mclk);
    per_addr = addr;
    per_din  = data;
    per_en   = en;
    per_we   = we;
    @(negedge mclk);
    per_en = 1'b0;
    per_we = 2'b00;
  endtask

  // Other lane carries the inverse
  task automatic write_reg(int port, int off, logic [7:0] data);
    if (off % 2 == 1) bus_cycle(word_addr(port, off / 2), {data, ~data}, 1'b1, 2'b10);
    else              bus_cycle(word_addr(port, off / 2), {~data, data}, 1'b1, 2'b01);
  endtask

  task automatic read_word(int port, int idx);
    bus_cycle(word_addr(port, idx), 16'($urandom), 1'b1, 2'b00);
  endtask

  task automatic set_pins(int port, logic [7:0] val);
    @(negedge mclk);
    if (port == 0) p1_din = val;
    else           p2_din = val;
  endtask

  task automatic report();
    int val_errs;
    int rst_errs;
    val_errs = uut.u_props.val_errs;
    rst_errs = uut.u_props.rst_errs;
    $display("Failed checks: value %0d, reset %0d, timeout %0d", val_errs, rst_errs,
             timed_out);
    if (val_errs == 0 && rst_errs == 0 && !timed_out) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  always @(posedge mclk) begin
    cycles++;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout: test sequence still running after %0d cycles", MAX_CYCLES);
      timed_out = 1'b1;
      report();
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    logic [7:0]  pat;
    logic [13:0] far;
    void'($urandom(32'h8c7d));
    mclk     = 1'b0;
    puc_rst  = 1'b1;
    per_addr = '0;
    per_din  = '0;
    per_en   = 1'b0;
    per_we   = 2'b00;
    p1_din   = '0;
    p2_din   = '0;
    repeat (8) @(posedge mclk);
    @(negedge mclk);
    puc_rst = 1'b0;
    repeat (2) @(negedge mclk);

    repeat (2) begin
      for (int p = 0; p < 2; p++) begin
        write_reg(p, `GPIO_REG_OUT, 8'($urandom));  // High lane
        write_reg(p, `GPIO_REG_DIR, 8'($urandom));
        write_reg(p, `GPIO_REG_SEL, 8'($urandom));
        for (int w = 0; w < 4; w++) read_word(p, w);
      end
    end

    for (int p = 0; p < 2; p++) begin
      set_pins(p, 8'($urandom));
      repeat (2) @(negedge mclk);
      read_word(p, 0);
    end

    // Selected edge sets flags and the opposite edge must not
    for (int p = 0; p < 2; p++) begin
      for (int ies = 0; ies < 2; ies++) begin
        pat = 8'($urandom) | 8'h01;
        set_pins(p, (ies == 1) ? 8'hff : 8'h00);
        write_reg(p, `GPIO_REG_IES, (ies == 1) ? 8'hff : 8'h00);
        write_reg(p, `GPIO_REG_IE, 8'hff);
        write_reg(p, `GPIO_REG_IFG, 8'h00);
        set_pins(p, (ies == 1) ? ~pat : pat);
        repeat (4) read_word(p, 1);
        write_reg(p, `GPIO_REG_IFG, 8'h00);  // Clears flag and irq
        read_word(p, 1);
        set_pins(p, (ies == 1) ? 8'hff : 8'h00);
        repeat (4) read_word(p, 1);
      end
    end

    for (int p = 0; p < 2; p++) begin
      far = word_addr(p, 0) ^ (14'd1 << (`GPIO_DEC_WD - 1));  // Outside the base
      bus_cycle(word_addr(p, 0), 16'($urandom), 1'b0, 2'b10);
      bus_cycle(word_addr(p, 1), 16'($urandom), 1'b0, 2'b00);
      bus_cycle(far, 16'($urandom), 1'b1, 2'b10);
      bus_cycle(far, 16'($urandom), 1'b1, 2'b00);
      write_reg(p, `GPIO_REG_IN, 8'($urandom));
      for (int w = 0; w < 4; w++) read_word(p, w);
    end

    report();
  end

endmodule

// ==== build.f ====
+incdir+common
common/gpio_pkg.sv
common/gpio_reg_if.sv
gpio_port/gpio_input_sync.sv
gpio_port/gpio_port.sv
verilog/gpio_reg_decoder.sv
verilog/gpio_top.sv
dv/gpio_props.sv
dv/gpio_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module gpio_tb -o gpio_sim

# Assertion errors must not stop the run before the closing line
sim_out=$(./obj_dir/gpio_sim +verilator+error+limit+10000 || true)
echo "$sim_out"

if echo "$sim_out" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1
